/* cell_search.f */
source/cell_search_pkg.sv
source/cic_decimator.sv
source/pss_correlator.sv
source/sync_controller.sv
source/sss_detector.sv
source/cell_search.sv
sim/clock_gen.sv
sim/result_checker.sv
sim/tb_cell_search.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_cell_search \
    -f cell_search.f -o sim_cell_search
./obj_dir/sim_cell_search | tee sim.log
if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

/* sim/cell_search_patterns.mem */
// kind n_id_2 n_id_1 amplitude n_id, one hex word per test
// kind 0 idle, 1 dc level, 2 cell id, 3 noise, 4 back to back cell id
0_0_0_00_0
1_0_0_1c_0
1_0_0_d8_0
2_0_0_20_0
2_1_0_20_1
2_2_0_20_2
2_0_1_20_3
2_1_1_20_4
2_2_1_20_5
2_0_2_20_6
2_1_2_20_7
2_2_2_20_8
2_0_3_20_9
2_1_3_20_a
2_2_3_20_b
3_0_0_08_0
4_1_2_20_7
4_2_1_20_5

/* sim/tb_cell_search.sv */
module tb_cell_search import cell_search_pkg::*; ();

    localparam int NUM_REC   = 18;
    localparam int THRESHOLD = 600;
    localparam int OFFSET    = 20;
    localparam int DC_PAIRS  = 16;
    localparam int PSS_START = 20;   // pair index of the first pss chip

    typedef struct packed {
        logic       valid;
        logic       start;
        logic       stop;
        iq_sample_t s;
    } stim_t;

    typedef struct packed {
        logic [3:0] kind;
        logic [3:0] n_id_2;
        logic [3:0] n_id_1;
        logic [7:0] amp;
        logic [3:0] n_id;
    } record_t;

    logic [23:0] rec_mem [NUM_REC];
    stim_t       stim_q [$];
    int          seed;
    int          cycle_cnt;
    int          cycle_limit;
    logic        running;

    logic        clk, reset_n;
    iq_sample_t  sample, dec_sample;
    logic        sample_valid, dec_valid, lock, cell_id_valid;
    cell_id_t    cell_id, exp_id;
    logic        test_start, test_stop, all_done;
    logic [3:0]  kind;
    logic [7:0]  amp;
    int          test_cnt, fail_cnt;

    clock_gen clock_gen_i (.clk_o(clk), .reset_no(reset_n));

    cell_search #(.PEAK_THRESHOLD(THRESHOLD), .SSS_OFFSET(OFFSET)) dut_i (
        .clk_i           (clk),
        .reset_ni        (reset_n),
        .sample_i        (sample),
        .sample_valid_i  (sample_valid),
        .dec_sample_o    (dec_sample),
        .dec_valid_o     (dec_valid),
        .lock_o          (lock),
        .cell_id_o       (cell_id),
        .cell_id_valid_o (cell_id_valid)
    );

    result_checker #(.DC_PAIRS(DC_PAIRS)) result_checker_i (
        .clk_i (clk), .reset_ni (reset_n),
        .dec_sample_i (dec_sample), .dec_valid_i (dec_valid), .lock_i (lock),
        .cell_id_i (cell_id), .cell_id_valid_i (cell_id_valid),
        .test_start_i (test_start), .test_stop_i (test_stop), .all_done_i (all_done),
        .kind_i (kind), .dc_value_i (amp), .exp_i (exp_id),
        .test_cnt_o (test_cnt), .fail_cnt_o (fail_cnt)
    );

    task automatic add_sample(input logic valid, input int re, input int im);
        stim_t e;
        e.valid = valid;
        e.start = 1'b0;
        e.stop  = 1'b0;
        e.s.re  = 8'(re);
        e.s.im  = 8'(im);
        stim_q.push_back(e);
    endtask

    // first decimated index whose best metric reaches the threshold
    // held chip pairs give y = (3*x[k] + x[k-1]) >>> 2
    function automatic int find_peak(input int n2, input int a);
        int x [PSS_START+PSS_LEN];
        int y, acc, best;
        int ys [PSS_START+PSS_LEN];
        for (int k = 0; k < PSS_START + PSS_LEN; k++) begin
            x[k] = (k < PSS_START) ? 0 : (PSS_SEQ[n2*PSS_LEN + k - PSS_START] ? a : -a);
            y = 3 * x[k] + ((k > 0) ? x[k-1] : 0);
            ys[k] = y >>> 2;
        end
        for (int k = PSS_START; k < PSS_START + PSS_LEN; k++) begin
            best = 0;
            for (int m = 0; m < 3; m++) begin
                acc = 0;
                for (int j = 0; j < PSS_LEN; j++)
                    acc += PSS_SEQ[m*PSS_LEN + j] ? ys[k-15+j] : -ys[k-15+j];
                if (2 * (acc < 0 ? -acc : acc) > best) best = 2 * (acc < 0 ? -acc : acc);
            end
            if (best >= THRESHOLD) return k;
        end
        return PSS_START + PSS_LEN - 1;
    endfunction

    task automatic build_test(input record_t r);
        int first, a, gap, tail, v;
        first = stim_q.size();
        case (r.kind)
            0: repeat (16) add_sample(1'b0, 0, 0);
            1: begin
                repeat (2 * DC_PAIRS) add_sample(1'b1, $signed(r.amp), $signed(r.amp));
                repeat (8) add_sample(1'b0, 0, 0);
            end
            3: begin
                repeat (2 * (PSS_START + 32)) add_sample(1'b1, $random(seed) % (int'(r.amp) + 1),
                                                         $random(seed) % (int'(r.amp) + 1));
                repeat (8) add_sample(1'b1, 0, 0);
            end
            default: begin
                a   = r.amp + ($random(seed) & 3);
                gap = find_peak(r.n_id_2, a) + OFFSET - (PSS_START + PSS_LEN);
                repeat (2 * PSS_START) add_sample(1'b1, 0, 0);
                for (int j = 0; j < PSS_LEN; j++) begin
                    v = PSS_SEQ[r.n_id_2*PSS_LEN + j] ? a : -a;
                    repeat (2) add_sample(1'b1, v, v);
                end
                repeat (2 * gap) add_sample(1'b1, 0, 0);
                for (int j = 0; j < SSS_LEN; j++) begin
                    v = SSS_SEQ[r.n_id_1*SSS_LEN + j] ? a : -a;
                    repeat (2) add_sample(1'b1, v, 0);   // sss on re only
                end
                tail = (r.kind == 4) ? 8 : 8 + 2 * ($random(seed) & 7);
                repeat (tail) add_sample(1'b1, 0, 0);
            end
        endcase
        stim_q[first].start = 1'b1;
        stim_q[stim_q.size()-1].stop = 1'b1;
    endtask

    always @(posedge clk) begin
        if (running) begin
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                $display("timeout: stimulus not finished after %0d cycles", cycle_limit);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    initial begin
        record_t r;
        int      test_idx;
        seed = 32'h3ebe9fd6;
        sample = '0;
        sample_valid = 1'b0;
        test_start = 1'b0;
        test_stop = 1'b0;
        all_done = 1'b0;
        kind = '0;
        amp = '0;
        exp_id = '0;
        running = 1'b0;
        cycle_cnt = 0;
        test_idx = 0;
        $readmemh("sim/cell_search_patterns.mem", rec_mem);
        for (int i = 0; i < NUM_REC; i++) build_test(record_t'(rec_mem[i]));
        cycle_limit = stim_q.size() + 200;
        wait (reset_n);
        running = 1'b1;
        foreach (stim_q[i]) begin
            @(negedge clk);
            sample       = stim_q[i].s;
            sample_valid = stim_q[i].valid;
            test_start   = stim_q[i].start;
            test_stop    = stim_q[i].stop;
            if (stim_q[i].start) begin
                r      = record_t'(rec_mem[test_idx]);
                kind   = r.kind;
                amp    = r.amp;
                exp_id = '{n_id_1: r.n_id_1[1:0], n_id_2: r.n_id_2[1:0], n_id: r.n_id};
            end
            if (stim_q[i].stop) test_idx++;
        end
        @(negedge clk);
        sample_valid = 1'b0;
        test_start   = 1'b0;
        test_stop    = 1'b0;
        all_done     = 1'b1;
        @(negedge clk);
        all_done = 1'b0;
        @(negedge clk);
        if (fail_cnt == 0 && test_cnt == NUM_REC) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sim/result_checker.sv */
module result_checker import cell_search_pkg::*; #(
    parameter int DC_PAIRS = 16
) (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  iq_sample_t                  dec_sample_i,
    input  logic                        dec_valid_i,
    input  logic                        lock_i,
    input  cell_id_t                    cell_id_i,
    input  logic                        cell_id_valid_i,
    input  logic                        test_start_i,
    input  logic                        test_stop_i,
    input  logic                        all_done_i,
    input  logic [3:0]                  kind_i,
    input  logic signed [SAMPLE_DW-1:0] dc_value_i,
    input  cell_id_t                    exp_i,
    output int                          test_cnt_o,
    output int                          fail_cnt_o
);

    int   dec_cnt;
    int   rep_cnt;
    logic lock_seen;
    logic test_bad;
    logic active;

    task automatic value_error(input string name, input int expected, input int actual);
        $display("Error: time %0t %s expected %0d got %0d", $time, name, expected, actual);
        test_bad = 1'b1;
    endtask

    task automatic other_error(input string what);
        $display("Failure at time %0t: %s", $time, what);
        test_bad = 1'b1;
    endtask

    always @(posedge clk_i) begin
        if (!reset_ni) begin
            active     = 1'b0;
            test_cnt_o = 0;
            fail_cnt_o = 0;
        end else begin
            if (test_start_i) begin
                active    = 1'b1;
                dec_cnt   = 0;
                rep_cnt   = 0;
                lock_seen = 1'b0;
                test_bad  = 1'b0;
                if ((kind_i == 2 || kind_i == 4) && lock_i)
                    other_error("lock_o still high when a new search starts");
            end else if (active) begin
                if (dec_valid_i) begin
                    dec_cnt++;
                    // first two outputs still hold the filter history
                    if (kind_i == 1 && dec_cnt >= 3) begin
                        if (dec_sample_i.re != dc_value_i)
                            value_error("dec_sample_o.re", dc_value_i, dec_sample_i.re);
                        if (dec_sample_i.im != dc_value_i)
                            value_error("dec_sample_o.im", dc_value_i, dec_sample_i.im);
                    end
                end
                if (lock_i) lock_seen = 1'b1;
                if (cell_id_valid_i) begin
                    rep_cnt++;
                    if (kind_i == 2 || kind_i == 4) begin
                        if (cell_id_i.n_id_1 != exp_i.n_id_1)
                            value_error("cell_id_o.n_id_1", exp_i.n_id_1, cell_id_i.n_id_1);
                        if (cell_id_i.n_id_2 != exp_i.n_id_2)
                            value_error("cell_id_o.n_id_2", exp_i.n_id_2, cell_id_i.n_id_2);
                        if (cell_id_i.n_id != exp_i.n_id)
                            value_error("cell_id_o.n_id", exp_i.n_id, cell_id_i.n_id);
                    end
                end
            end
            if (test_stop_i && active) begin
                case (kind_i)
                    0: if (dec_cnt != 0 || lock_seen || rep_cnt != 0)
                        other_error("an output went high before any input was sent");
                    1: if (dec_cnt != DC_PAIRS)
                        value_error("dec_valid_o count", DC_PAIRS, dec_cnt);
                    3: if (lock_seen || rep_cnt != 0)
                        other_error("lock or cell id report on a record without a signal");
                    default: if (rep_cnt != 1)
                        value_error("cell_id_valid_o count", 1, rep_cnt);
                endcase
                test_cnt_o++;
                if (test_bad) fail_cnt_o++;
                $display("test %0d kind %0d: %s", test_cnt_o, kind_i, test_bad ? "bad" : "ok");
                active = 1'b0;
            end
            if (all_done_i) begin
                $display("tests run %0d, passed %0d, failed %0d",
                         test_cnt_o, test_cnt_o - fail_cnt_o, fail_cnt_o);
            end
        end
    end

endmodule

/* sim/clock_gen.sv */
module clock_gen (
    output logic clk_o,
    output logic reset_no
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        reset_no = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        reset_no = 1'b1;
    end

endmodule

/* source/cell_search.sv */
module cell_search import cell_search_pkg::*; #(
    parameter int unsigned PEAK_THRESHOLD = 600,
    parameter int unsigned SSS_OFFSET     = 20
) (
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_sample_t sample_i,
    input  logic       sample_valid_i,
    output iq_sample_t dec_sample_o,
    output logic       dec_valid_o,
    output logic       lock_o,
    output cell_id_t   cell_id_o,
    output logic       cell_id_valid_o
);

    logic signed [SAMPLE_DW-1:0] dec_re, dec_im;
    iq_sample_t                  dec_sample;
    logic                        dec_valid;
    pss_result_t                 pss_result;
    logic                        window;
    logic [1:0]                  n_id_2;
    logic                        sss_done;

    cic_decimator #(.DW(SAMPLE_DW)) cic_re (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .data_i   (sample_i.re),
        .valid_i  (sample_valid_i),
        .data_o   (dec_re),
        .valid_o  (dec_valid)
    );

    // same valid as the re path, its own strobe is not needed
    cic_decimator #(.DW(SAMPLE_DW)) cic_im (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .data_i   (sample_i.im),
        .valid_i  (sample_valid_i),
        .data_o   (dec_im),
        .valid_o  ()
    );

    assign dec_sample   = '{re: dec_re, im: dec_im};
    assign dec_sample_o = dec_sample;
    assign dec_valid_o  = dec_valid;

    pss_correlator pss_correlator_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .sample_i (dec_sample),
        .valid_i  (dec_valid),
        .result_o (pss_result)
    );

    sync_controller #(
        .PEAK_THRESHOLD (PEAK_THRESHOLD),
        .SSS_OFFSET     (SSS_OFFSET)
    ) sync_controller_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .result_i    (pss_result),
        .dec_valid_i (dec_valid),
        .done_i      (sss_done),
        .window_o    (window),
        .n_id_2_o    (n_id_2),
        .lock_o      (lock_o)
    );

    sss_detector sss_detector_i (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .sample_i        (dec_sample),
        .window_i        (window),
        .n_id_2_i        (n_id_2),
        .done_o          (sss_done),
        .cell_id_o       (cell_id_o),
        .cell_id_valid_o (cell_id_valid_o)
    );

endmodule

/* source/sss_detector.sv */
module sss_detector import cell_search_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_sample_t sample_i,
    input  logic       window_i,
    input  logic [1:0] n_id_2_i,
    output logic       done_o,
    output cell_id_t   cell_id_o,
    output logic       cell_id_valid_o
);

    localparam int CNT_DW   = $clog2(SSS_LEN);
    localparam int AGREE_DW = $clog2(SSS_LEN + 1);

    logic [SSS_LEN-1:0] bits;        // bit j is the j-th windowed sample
    logic [SSS_LEN-1:0] bits_next;
    logic [CNT_DW-1:0]  bit_cnt;
    logic               last_bit;
    logic [1:0]         best_idx;

    // bpsk hard decision, 1 when re >= 0
    assign bits_next = {~sample_i.re[SAMPLE_DW-1], bits[SSS_LEN-1:1]};
    assign last_bit  = window_i && (bit_cnt == CNT_DW'(SSS_LEN - 1));

    always_comb begin
        logic [SSS_LEN-1:0]  agree;
        logic [AGREE_DW-1:0] score;
        logic [AGREE_DW-1:0] best_score;
        best_idx   = '0;
        best_score = '0;
        for (int h = 0; h < NUM_SSS; h++) begin
            agree = ~(bits_next ^ SSS_SEQ[h*SSS_LEN +: SSS_LEN]);
            score = '0;
            for (int j = 0; j < SSS_LEN; j++) begin
                score = score + AGREE_DW'(agree[j]);
            end
            if (h == 0 || score > best_score) begin
                best_idx   = 2'(h);
                best_score = score;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            bit_cnt         <= '0;
            cell_id_valid_o <= 1'b0;
        end else begin
            cell_id_valid_o <= last_bit;
            if (window_i) bit_cnt <= bit_cnt + 1'b1;   // wraps after the last chip
        end
    end

    always_ff @(posedge clk_i) begin
        if (window_i) bits <= bits_next;
        if (last_bit) begin
            cell_id_o.n_id_1 <= best_idx;
            cell_id_o.n_id_2 <= n_id_2_i;
            cell_id_o.n_id   <= 4'(best_idx) * 4'd3 + {2'b00, n_id_2_i};
        end
    end

    assign done_o = cell_id_valid_o;  // controller goes back to search

endmodule

/* source/sync_controller.sv */
module sync_controller import cell_search_pkg::*; #(
    parameter int unsigned PEAK_THRESHOLD = 600,
    parameter int unsigned SSS_OFFSET     = 20
) (
    input  logic        clk_i,
    input  logic        reset_ni,
    input  pss_result_t result_i,
    input  logic        dec_valid_i,
    input  logic        done_i,
    output logic        window_o,
    output logic [1:0]  n_id_2_o,
    output logic        lock_o
);

    localparam int CNT_MAX = (SSS_OFFSET > SSS_LEN) ? SSS_OFFSET : SSS_LEN;
    localparam int CNT_DW  = $clog2(CNT_MAX + 1);

    typedef enum logic [1:0] {
        S_SEARCH,
        S_OFFSET,
        S_COLLECT,
        S_WAIT
    } state_t;

    state_t            state;
    logic [CNT_DW-1:0] cnt;     // decimated samples in the current state
    logic              peak;

    assign peak = result_i.valid && (result_i.metric >= METRIC_DW'(PEAK_THRESHOLD));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state <= S_SEARCH;
            cnt   <= '0;
        end else begin
            case (state)
                S_SEARCH: if (peak) begin
                    cnt   <= '0;
                    state <= (SSS_OFFSET > 1) ? S_OFFSET : S_COLLECT;
                end
                S_OFFSET: if (dec_valid_i) begin
                    if (cnt == CNT_DW'(SSS_OFFSET - 2)) begin
                        cnt   <= '0;
                        state <= S_COLLECT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_COLLECT: if (dec_valid_i) begin
                    if (cnt == CNT_DW'(SSS_LEN - 1)) begin
                        cnt   <= '0;
                        state <= S_WAIT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_WAIT: if (done_i) state <= S_SEARCH;
                default: state <= S_SEARCH;
            endcase
        end
    end

    // id of the locked peak, held for the detector
    always_ff @(posedge clk_i) begin
        if (state == S_SEARCH && peak) n_id_2_o <= result_i.n_id_2;
    end

    assign window_o = (state == S_COLLECT) && dec_valid_i;
    assign lock_o   = (state != S_SEARCH);

endmodule

/* source/pss_correlator.sv */
module pss_correlator import cell_search_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_ni,
    input  iq_sample_t  sample_i,
    input  logic        valid_i,
    output pss_result_t result_o
);

    localparam int NUM_PSS = 3;
    localparam int SUM_DW  = SAMPLE_DW + $clog2(PSS_LEN) + 1;

    iq_sample_t           hist [PSS_LEN-1];   // older samples, hist[0] newest
    iq_sample_t           window [PSS_LEN];
    logic [1:0]           best_idx;
    logic [METRIC_DW-1:0] best_metric;

    // window[0] is the incoming sample and lines up with the last chip
    always_comb begin
        window[0] = sample_i;
        for (int m = 1; m < PSS_LEN; m++) begin
            window[m] = hist[m-1];
        end
    end

    always_comb begin
        logic signed [SUM_DW-1:0] acc_re;
        logic signed [SUM_DW-1:0] acc_im;
        logic [SUM_DW-1:0]        abs_re;
        logic [SUM_DW-1:0]        abs_im;
        logic [METRIC_DW-1:0]     metric;
        best_idx    = '0;
        best_metric = '0;
        for (int k = 0; k < NUM_PSS; k++) begin
            acc_re = '0;
            acc_im = '0;
            for (int j = 0; j < PSS_LEN; j++) begin
                if (PSS_SEQ[k*PSS_LEN + j]) begin
                    acc_re = acc_re + window[PSS_LEN-1-j].re;
                    acc_im = acc_im + window[PSS_LEN-1-j].im;
                end else begin
                    acc_re = acc_re - window[PSS_LEN-1-j].re;
                    acc_im = acc_im - window[PSS_LEN-1-j].im;
                end
            end
            abs_re = (acc_re < 0) ? -acc_re : acc_re;
            abs_im = (acc_im < 0) ? -acc_im : acc_im;
            metric = METRIC_DW'(abs_re) + METRIC_DW'(abs_im);
            if (k == 0 || metric > best_metric) begin  // strict compare, lowest index wins ties
                best_idx    = 2'(k);
                best_metric = metric;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int m = 0; m < PSS_LEN-1; m++) begin
                hist[m] <= '0;
            end
            result_o.valid <= 1'b0;
        end else begin
            result_o.valid <= valid_i;
            if (valid_i) begin
                hist[0] <= sample_i;
                for (int m = 1; m < PSS_LEN-1; m++) begin
                    hist[m] <= hist[m-1];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            result_o.n_id_2 <= best_idx;
            result_o.metric <= best_metric;
        end
    end

endmodule

/* source/cic_decimator.sv */
module cic_decimator #(
    parameter int DW = 8
) (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic signed [DW-1:0] data_i,
    input  logic                 valid_i,
    output logic signed [DW-1:0] data_o,
    output logic                 valid_o
);

    localparam int W = DW + 2;  // growth of N=2, R=2

    logic signed [W-1:0] integ1, integ2;
    logic signed [W-1:0] integ1_next, integ2_next;
    logic signed [W-1:0] comb1_dly, comb2_dly;
    logic signed [W-1:0] comb1, comb2;
    logic                phase;    // high on the second input of a pair

    always_comb begin
        integ1_next = integ1 + W'(data_i);
        integ2_next = integ2 + integ1_next;
        comb1       = integ2_next - comb1_dly;
        comb2       = comb1 - comb2_dly;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            integ1    <= '0;
            integ2    <= '0;
            comb1_dly <= '0;
            comb2_dly <= '0;
            phase     <= 1'b0;
            valid_o   <= 1'b0;
        end else begin
            valid_o <= valid_i && phase;
            if (valid_i) begin
                integ1 <= integ1_next;
                integ2 <= integ2_next;
                phase  <= ~phase;
                if (phase) begin
                    // combs only run at the decimated rate
                    comb1_dly <= integ2_next;
                    comb2_dly <= comb1;
                end
            end
        end
    end

    // gain of 4 removed by dropping the two lsbs
    always_ff @(posedge clk_i) begin
        if (valid_i && phase) begin
            data_o <= comb2[W-1:2];
        end
    end

endmodule

/* source/cell_search_pkg.sv */
package cell_search_pkg;

    localparam int SAMPLE_DW = 8;
    localparam int PSS_LEN   = 16;
    localparam int SSS_LEN   = 16;
    localparam int NUM_SSS   = 4;
    localparam int METRIC_DW = 14;

    // one complex baseband sample, re in the upper byte
    typedef struct packed {
        logic signed [SAMPLE_DW-1:0] re;
        logic signed [SAMPLE_DW-1:0] im;
    } iq_sample_t;

    typedef struct packed {
        logic                 valid;
        logic [1:0]           n_id_2;
        logic [METRIC_DW-1:0] metric;   // |sum re| + |sum im| of the best sequence
    } pss_result_t;

    typedef struct packed {
        logic [1:0] n_id_1;
        logic [1:0] n_id_2;
        logic [3:0] n_id;   // 3*n_id_1 + n_id_2
    } cell_id_t;

    // sequence k sits at [k*PSS_LEN +: PSS_LEN], bit j is chip j in send order
    // 1 means +1, 0 means -1
    localparam logic [3*PSS_LEN-1:0] PSS_SEQ = {
        16'hb295,   // n_id_2 = 2
        16'h6c4b,   // n_id_2 = 1
        16'h1af3    // n_id_2 = 0
    };

    // pairwise hamming distance of 8
    localparam logic [NUM_SSS*SSS_LEN-1:0] SSS_SEQ = {
        16'h6996,   // n_id_1 = 3
        16'h33cc,
        16'h0ff0,
        16'h5a5a    // n_id_1 = 0
    };

endpackage
